// File: build.f
logic/cpuPkg.sv
logic/stageIf.sv
logic/fetchStage.sv
logic/controlDecoder.sv
logic/registerFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/cpuTop.sv
bench/cpuProps_props.sv
bench/cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the pipelined CPU testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module cpuTb -f build.f -o cpuSim

./obj_dir/cpuSim

// File: bench/cpuTb.sv
module cpuTb import cpuPkg::*; ();

    localparam int period = 100;
    localparam int resetCycles = 4;
    localparam int maxProgram = 40;
    localparam int directedTests = 4;
    localparam int randomPrograms = 3;
    localparam int startWord = int'(resetPc >> 2);

    logic clk;
    logic reset;
    logic loadEnable;
    logic loadToData;
    memIndex loadAddr;
    dataWord loadData;
    dataWord pc;
    logic wbEnable;
    regIndex wbDest;
    dataWord wbData;

    instrWord prog[$];
    instrWord progImage[memWords];
    dataWord dataImage[memWords];
    regIndex expDest[$];
    dataWord expData[$];
    logic [31:0] lfsrState = 32'hedb7_eb02;

    cpuTop uut (
        .clk(clk),
        .reset(reset),
        .loadEnable(loadEnable),
        .loadToData(loadToData),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .pc(pc),
        .wbEnable(wbEnable),
        .wbDest(wbDest),
        .wbData(wbData)
    );

    always #(period / 2) clk = ~clk;

    // reset, memory load and the writeback window of one program
    function automatic int testCycles(int len);
        return 1 + resetCycles + 2 * memWords + 1 + 2 * len + 20 + 1;
    endfunction

    initial begin
        #(period * (resetCycles + (directedTests + randomPrograms) * testCycles(maxProgram)));
        $display("Finished with errors");
        $fatal(1, "watchdog expired before the tests completed");
    end

    // one LFSR step per bit
    function automatic dataWord randomBits(int count);
        dataWord value;
        logic lsb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lsb = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (lsb) begin
                lfsrState = lfsrState ^ 32'h8020_0003;
            end
            value = {value[30:0], lsb};
        end
        return value;
    endfunction

    function automatic instrWord encodeR(logic [5:0] func, regIndex rd, regIndex rs, regIndex rt);
        return {opRType, rs, rt, rd, 5'd0, func};
    endfunction

    function automatic instrWord encodeMem(logic [5:0] op, regIndex rt, regIndex base,
                                           logic [15:0] offset);
        return {op, base, rt, offset};
    endfunction

    function automatic dataWord fillPattern(int i);
        return 32'h5a00_0000 + dataWord'(i) * 32'h0001_0001;
    endfunction

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %s got %h expected %h", name, got, expected);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic clearImages();
        for (int i = 0; i < memWords; i++) begin
            dataImage[i] = fillPattern(i);
        end
        prog.delete();
    endtask

    // sequential reference, one instruction at a time
    task automatic predictWritebacks(int len);
        dataWord regs[32];
        dataWord mem[memWords];
        instrWord w;
        dataWord a, b, imm, addr, value;
        regIndex dest;
        memIndex idx;
        logic writes;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < memWords; i++) begin
            mem[i] = dataImage[i];
        end
        expDest.delete();
        expData.delete();
        for (int k = 0; k < len; k++) begin
            w = progImage[(startWord + k) % memWords];
            a = regs[w[25:21]];
            b = regs[w[20:16]];
            imm = {{16{w[15]}}, w[15:0]};
            addr = a + imm;
            idx = addr[7:2];
            writes = 1'b0;
            dest = w[15:11];
            value = '0;
            if (w[31:26] == opRType) begin
                writes = 1'b1;
                case (w[5:0])
                    funcAdd: value = a + b;
                    funcSub: value = a - b;
                    funcAnd: value = a & b;
                    funcOr: value = a | b;
                    funcXor: value = a ^ b;
                    default: writes = 1'b0;
                endcase
            end else if (w[31:26] == opLoad) begin
                writes = 1'b1;
                dest = w[20:16];
                value = mem[idx];
            end else if (w[31:26] == opStore) begin
                mem[idx] = b;
            end
            if (writes && dest != '0) begin
                regs[dest] = value;
                expDest.push_back(dest);
                expData.push_back(value);
            end
        end
    endtask

    task automatic loadMemories();
        for (int i = 0; i < memWords; i++) begin
            @(negedge clk);
            loadEnable = 1'b1;
            loadToData = 1'b0;
            loadAddr = memIndex'(i);
            loadData = progImage[i];
            @(negedge clk);
            loadToData = 1'b1;
            loadData = dataImage[i];
        end
        @(negedge clk);
        loadEnable = 1'b0;
        loadToData = 1'b0;
    endtask

    task automatic runProgram(string name);
        int len;
        int limit;
        int waited;
        len = prog.size();
        for (int i = 0; i < memWords; i++) begin
            progImage[i] = '0;
        end
        for (int k = 0; k < len; k++) begin
            progImage[(startWord + k) % memWords] = prog[k];
        end
        @(negedge clk);
        reset = 1'b1;
        repeat (resetCycles) @(negedge clk);
        loadMemories();
        predictWritebacks(len);
        // execution starts at byte address 100
        checkValue({name, " pc"}, pc, resetPc);
        reset = 1'b0;
        limit = 2 * len + 20;
        waited = 0;
        while (expDest.size() > 0) begin
            @(negedge clk);
            waited++;
            if (wbEnable) begin
                checkValue({name, " wbDest"}, 32'(wbDest), 32'(expDest[0]));
                checkValue({name, " wbData"}, wbData, expData[0]);
                void'(expDest.pop_front());
                void'(expData.pop_front());
            end else if (waited > limit) begin
                $display("%s: expected writeback to r%0d never arrived within %0d cycles",
                         name, expDest[0], limit);
                $display("Finished with errors");
                $fatal(1, "missing writeback");
            end
        end
    endtask

    task automatic testLoads();
        clearImages();
        // pointer used as a base register
        dataImage[1] = 32'd40;
        prog.push_back(encodeMem(opLoad, 5'd1, 5'd0, 16'd4));
        prog.push_back(encodeMem(opLoad, 5'd2, 5'd1, 16'd12));
        prog.push_back(encodeMem(opLoad, 5'd3, 5'd1, 16'hfff8));
        prog.push_back(encodeMem(opLoad, 5'd4, 5'd0, 16'd252));
        prog.push_back(encodeMem(opLoad, 5'd5, 5'd0, 16'd0));
        prog.push_back(encodeMem(opLoad, 5'd6, 5'd1, 16'd0));
        runProgram("loads");
    endtask

    task automatic testAluChain();
        clearImages();
        prog.push_back(encodeMem(opLoad, 5'd1, 5'd0, 16'd0));
        prog.push_back(encodeMem(opLoad, 5'd2, 5'd0, 16'd4));
        prog.push_back(encodeMem(opLoad, 5'd3, 5'd0, 16'd8));
        prog.push_back(encodeR(funcAdd, 5'd4, 5'd1, 5'd2));
        prog.push_back(encodeR(funcSub, 5'd5, 5'd4, 5'd3));
        prog.push_back(encodeR(funcAnd, 5'd6, 5'd5, 5'd3));
        prog.push_back(encodeR(funcOr, 5'd7, 5'd4, 5'd6));
        prog.push_back(encodeR(funcXor, 5'd8, 5'd5, 5'd7));
        prog.push_back(encodeR(funcAdd, 5'd9, 5'd6, 5'd8));
        prog.push_back(encodeR(funcSub, 5'd10, 5'd9, 5'd8));
        prog.push_back(encodeR(funcXor, 5'd11, 5'd8, 5'd1));
        runProgram("alu chain");
    endtask

    task automatic testLoadUse();
        clearImages();
        dataImage[6] = 32'd60;
        prog.push_back(encodeMem(opLoad, 5'd1, 5'd0, 16'd12));
        prog.push_back(encodeR(funcAdd, 5'd2, 5'd1, 5'd1));
        prog.push_back(encodeMem(opLoad, 5'd3, 5'd0, 16'd16));
        prog.push_back(encodeMem(opStore, 5'd3, 5'd0, 16'd40));
        prog.push_back(encodeMem(opLoad, 5'd4, 5'd0, 16'd40));
        prog.push_back(encodeMem(opLoad, 5'd6, 5'd0, 16'd24));
        prog.push_back(encodeMem(opStore, 5'd2, 5'd6, 16'd0));
        prog.push_back(encodeMem(opLoad, 5'd7, 5'd6, 16'd0));
        prog.push_back(encodeR(funcAdd, 5'd8, 5'd7, 5'd4));
        runProgram("load use");
    endtask

    task automatic testZeroAndNops();
        clearImages();
        prog.push_back(encodeMem(opLoad, 5'd0, 5'd0, 16'd4));
        prog.push_back(encodeMem(opLoad, 5'd1, 5'd0, 16'd8));
        prog.push_back(encodeR(funcAdd, 5'd0, 5'd1, 5'd1));
        prog.push_back(encodeR(funcOr, 5'd2, 5'd0, 5'd1));
        prog.push_back(32'h0000_0000);
        // unknown opcode, then unknown function code
        prog.push_back({6'b111111, 5'd3, 5'd1, 16'h1800});
        prog.push_back(encodeR(6'b000111, 5'd3, 5'd1, 5'd1));
        prog.push_back(encodeR(funcXor, 5'd4, 5'd3, 5'd0));
        prog.push_back(encodeR(funcAdd, 5'd5, 5'd0, 5'd0));
        runProgram("zero and nops");
    endtask

    task automatic buildRandomProgram();
        int kind;
        regIndex rd, rs, rt;
        dataWord word;
        logic [15:0] offset;
        for (int k = 0; k < maxProgram; k++) begin
            kind = int'(randomBits(3)) % 7;
            rd = regIndex'(randomBits(3));
            rs = regIndex'(randomBits(3));
            rt = regIndex'(randomBits(3));
            word = randomBits(4);
            offset = {10'd0, word[3:0], 2'b00};
            case (kind)
                0: prog.push_back(encodeR(funcAdd, rd, rs, rt));
                1: prog.push_back(encodeR(funcSub, rd, rs, rt));
                2: prog.push_back(encodeR(funcAnd, rd, rs, rt));
                3: prog.push_back(encodeR(funcOr, rd, rs, rt));
                4: prog.push_back(encodeR(funcXor, rd, rs, rt));
                5: prog.push_back(encodeMem(opLoad, rt, 5'd0, offset));
                default: prog.push_back(encodeMem(opStore, rt, 5'd0, offset));
            endcase
        end
    endtask

    task automatic testRandomPrograms();
        for (int p = 0; p < randomPrograms; p++) begin
            clearImages();
            buildRandomProgram();
            runProgram($sformatf("random %0d", p));
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        loadEnable = 1'b0;
        loadToData = 1'b0;
        loadAddr = '0;
        loadData = '0;
        repeat (resetCycles) @(negedge clk);
        testLoads();
        testAluChain();
        testLoadUse();
        testZeroAndNops();
        testRandomPrograms();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: bench/cpuProps_props.sv
module cpuProps import cpuPkg::*; (
    input logic clk,
    input logic reset,
    input dataWord pc,
    input logic wbEnable,
    input regIndex wbDest
);

    // MEM/WB is cleared by reset, and EX/MEM one stage earlier
    wbQuietAfterReset: assert property (
        @(posedge clk) ($past(reset) || $past(reset, 2)) |-> !wbEnable
    ) else $error("wbEnable high during or right after reset");

    wbDestNonzero: assert property (
        @(posedge clk) wbEnable |-> wbDest != '0
    ) else $error("writeback pulse to register 0");

    // pc only stalls or steps by one word
    pcStep: assert property (
        @(posedge clk) disable iff (reset)
        !$past(reset) |-> (pc == $past(pc) || pc == $past(pc) + 32'd4)
    ) else $error("pc moved from %h to %h", $past(pc), pc);

endmodule

bind cpuTop cpuProps props (
    .clk(clk),
    .reset(reset),
    .pc(pc),
    .wbEnable(wbEnable),
    .wbDest(wbDest)
);

// File: logic/cpuTop.sv
module cpuTop import cpuPkg::*; (
    input logic clk,
    input logic reset,
    input logic loadEnable,
    input logic loadToData,
    input memIndex loadAddr,
    input dataWord loadData,
    output dataWord pc,
    output logic wbEnable,
    output regIndex wbDest,
    output dataWord wbData
);

    logic stall;
    instrWord instr;
    dataWord memValue;

    idExeIf idExe ();
    exeMemIf exeMem ();

    fetchStage fetch (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .loadEnable(loadEnable),
        .loadToData(loadToData),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .pc(pc),
        .instr(instr)
    );

    decodeStage decode (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .wbEnable(wbEnable),
        .wbDest(wbDest),
        .wbData(wbData),
        .memValue(memValue),
        .toExe(idExe.source),
        .exeView(idExe.monitor),
        .memView(exeMem.monitor),
        .stall(stall)
    );

    executeStage execute (
        .clk(clk),
        .reset(reset),
        .fromDec(idExe.sink),
        .toMem(exeMem.source)
    );

    memoryStage memory (
        .clk(clk),
        .reset(reset),
        .fromExe(exeMem.sink),
        .loadEnable(loadEnable),
        .loadToData(loadToData),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .memValue(memValue),
        .wbEnable(wbEnable),
        .wbDest(wbDest),
        .wbData(wbData)
    );

endmodule

// File: logic/memoryStage.sv
module memoryStage import cpuPkg::*; (
    input logic clk,
    input logic reset,
    exeMemIf.sink fromExe,
    input logic loadEnable,
    input logic loadToData,
    input memIndex loadAddr,
    input dataWord loadData,
    output dataWord memValue,
    output logic wbEnable,
    output regIndex wbDest,
    output dataWord wbData
);

    dataWord dmem [memWords];
    dataWord loadWord;

    // load port has priority over a store
    always_ff @(posedge clk) begin
        if (loadEnable && loadToData) begin
            dmem[loadAddr] <= loadData;
        end else if (fromExe.memWrite) begin
            dmem[fromExe.aluResult[7:2]] <= fromExe.storeData;
        end
    end

    assign loadWord = dmem[fromExe.aluResult[7:2]];
    assign memValue = fromExe.memToReg ? loadWord : fromExe.aluResult;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (reset) begin
            wbEnable <= 1'b0;
        end else begin
            wbEnable <= fromExe.regWrite && fromExe.dest != '0;
        end
    end

    always_ff @(posedge clk) begin
        wbDest <= fromExe.dest;
        wbData <= memValue;
    end

endmodule

// File: logic/executeStage.sv
module executeStage import cpuPkg::*; (
    input logic clk,
    input logic reset,
    idExeIf.sink fromDec,
    exeMemIf.source toMem
);

    dataWord operandB;
    dataWord result;

    assign operandB = fromDec.aluSrcImm ? fromDec.imm : fromDec.opB;
    assign result = aluCompute(fromDec.aluFn, fromDec.opA, operandB);

    always_ff @(posedge clk) begin
        if (reset) begin
            toMem.regWrite <= 1'b0;
            toMem.memToReg <= 1'b0;
            toMem.memWrite <= 1'b0;
        end else begin
            toMem.regWrite <= fromDec.regWrite;
            toMem.memToReg <= fromDec.memToReg;
            toMem.memWrite <= fromDec.memWrite;
        end
    end

    // opB still holds rt, which is the store data
    always_ff @(posedge clk) begin
        toMem.dest <= fromDec.dest;
        toMem.aluResult <= result;
        toMem.storeData <= fromDec.opB;
    end

endmodule

// File: logic/decodeStage.sv
module decodeStage import cpuPkg::*; (
    input logic clk,
    input logic reset,
    input instrWord instr,
    input logic wbEnable,
    input regIndex wbDest,
    input dataWord wbData,
    input dataWord memValue,
    idExeIf.source toExe,
    idExeIf.monitor exeView,
    exeMemIf.monitor memView,
    output logic stall
);

    regIndex rs, rt, rd;
    logic regWrite, memToReg, memWrite, aluSrcImm, destIsRt, usesRt;
    aluOp aluFn;
    dataWord regA, regB, exeResult, opA, opB;
    fwdSel selA, selB;

    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];

    controlDecoder ctrl (
        .instr(instr),
        .regWrite(regWrite),
        .memToReg(memToReg),
        .memWrite(memWrite),
        .aluSrcImm(aluSrcImm),
        .destIsRt(destIsRt),
        .usesRt(usesRt),
        .aluFn(aluFn)
    );

    registerFile regs (
        .clk(clk),
        .reset(reset),
        .readA(rs),
        .readB(rt),
        .writeDest(wbDest),
        .writeEnable(wbEnable),
        .writeData(wbData),
        .dataA(regA),
        .dataB(regB)
    );

    // newest producer first, loads in execute are left to the stall
    function automatic fwdSel pickSource(regIndex src);
        if (src == '0) begin
            return fwdReg;
        end
        if (exeView.regWrite && !exeView.memToReg && exeView.dest == src) begin
            return fwdExe;
        end
        if (memView.regWrite && memView.dest == src) begin
            return fwdMem;
        end
        return fwdReg;
    endfunction

    function automatic dataWord pickValue(fwdSel sel, dataWord fromReg, dataWord fromExe,
                                          dataWord fromMem);
        case (sel)
            fwdExe: return fromExe;
            fwdMem: return fromMem;
            default: return fromReg;
        endcase
    endfunction

    assign exeResult = aluCompute(exeView.aluFn, exeView.opA,
                                  exeView.aluSrcImm ? exeView.imm : exeView.opB);

    always_comb begin
        selA = pickSource(rs);
        selB = pickSource(rt);
    end

    assign opA = pickValue(selA, regA, exeResult, memValue);
    assign opB = pickValue(selB, regB, exeResult, memValue);

    // load-use hazard
    assign stall = exeView.regWrite && exeView.memToReg && exeView.dest != '0
                   && (exeView.dest == rs || (usesRt && exeView.dest == rt));

    always_ff @(posedge clk) begin
        if (reset || stall) begin
            toExe.regWrite <= 1'b0;
            toExe.memToReg <= 1'b0;
            toExe.memWrite <= 1'b0;
        end else begin
            toExe.regWrite <= regWrite;
            toExe.memToReg <= memToReg;
            toExe.memWrite <= memWrite;
        end
    end

    always_ff @(posedge clk) begin
        toExe.aluFn <= aluFn;
        toExe.aluSrcImm <= aluSrcImm;
        toExe.dest <= destIsRt ? rt : rd;
        toExe.opA <= opA;
        toExe.opB <= opB;
        toExe.imm <= {{16{instr[15]}}, instr[15:0]};
    end

endmodule

// File: logic/registerFile.sv
module registerFile import cpuPkg::*; (
    input logic clk,
    input logic reset,
    input regIndex readA,
    input regIndex readB,
    input regIndex writeDest,
    input logic writeEnable,
    input dataWord writeData,
    output dataWord dataA,
    output dataWord dataB
);

    dataWord regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeDest != '0) begin
            regs[writeDest] <= writeData;
        end
    end

    // r0 is hardwired, same-cycle write is passed through
    function automatic dataWord readPort(regIndex idx);
        if (idx == '0) begin
            return '0;
        end
        if (writeEnable && writeDest == idx) begin
            return writeData;
        end
        return regs[idx];
    endfunction

    always_comb begin
        dataA = readPort(readA);
        dataB = readPort(readB);
    end

endmodule

// File: logic/controlDecoder.sv
module controlDecoder import cpuPkg::*; (
    input instrWord instr,
    output logic regWrite,
    output logic memToReg,
    output logic memWrite,
    output logic aluSrcImm,
    output logic destIsRt,
    output logic usesRt,
    output aluOp aluFn
);

    logic funcKnown;

    always_comb begin
        regWrite = 1'b0;
        memToReg = 1'b0;
        memWrite = 1'b0;
        aluSrcImm = 1'b0;
        destIsRt = 1'b0;
        usesRt = 1'b0;
        aluFn = aluAdd;
        funcKnown = 1'b1;
        case (instr[31:26])
            opRType: begin
                case (instr[5:0])
                    funcAdd: aluFn = aluAdd;
                    funcSub: aluFn = aluSub;
                    funcAnd: aluFn = aluAnd;
                    funcOr: aluFn = aluOr;
                    funcXor: aluFn = aluXor;
                    default: funcKnown = 1'b0;
                endcase
                regWrite = funcKnown;
                usesRt = funcKnown;
            end
            opLoad: begin
                regWrite = 1'b1;
                memToReg = 1'b1;
                aluSrcImm = 1'b1;
                destIsRt = 1'b1;
            end
            opStore: begin
                memWrite = 1'b1;
                aluSrcImm = 1'b1;
                // store data comes from rt
                usesRt = 1'b1;
            end
            default: funcKnown = 1'b0;
        endcase
    end

endmodule

// File: logic/fetchStage.sv
module fetchStage import cpuPkg::*; (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic loadEnable,
    input logic loadToData,
    input memIndex loadAddr,
    input dataWord loadData,
    output dataWord pc,
    output instrWord instr
);

    instrWord imem [memWords];
    instrWord fetched;

    always_ff @(posedge clk) begin
        if (loadEnable && !loadToData) begin
            imem[loadAddr] <= loadData;
        end
    end

    // word addressed
    assign fetched = imem[pc[7:2]];

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID, zero decodes as a no-op
    always_ff @(posedge clk) begin
        if (reset) begin
            instr <= '0;
        end else if (!stall) begin
            instr <= fetched;
        end
    end

endmodule

// File: logic/stageIf.sv
interface idExeIf import cpuPkg::*; ();
    logic regWrite;
    logic memToReg;
    logic memWrite;
    aluOp aluFn;
    logic aluSrcImm;
    regIndex dest;
    dataWord opA, opB, imm;

    modport source (output regWrite, memToReg, memWrite, aluFn, aluSrcImm, dest, opA, opB, imm);
    modport sink (input regWrite, memToReg, memWrite, aluFn, aluSrcImm, dest, opA, opB, imm);
    // decode recomputes the execute result from these
    modport monitor (input regWrite, memToReg, aluFn, aluSrcImm, dest, opA, opB, imm);
endinterface

interface exeMemIf import cpuPkg::*; ();
    logic regWrite;
    logic memToReg;
    logic memWrite;
    regIndex dest;
    dataWord aluResult;
    dataWord storeData;

    modport source (output regWrite, memToReg, memWrite, dest, aluResult, storeData);
    modport sink (input regWrite, memToReg, memWrite, dest, aluResult, storeData);
    modport monitor (input regWrite, memToReg, dest);
endinterface

// File: logic/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] dataWord;
    typedef logic [31:0] instrWord;
    typedef logic [4:0] regIndex;
    typedef logic [5:0] memIndex;

    localparam int memWords = 64;
    localparam dataWord resetPc = 32'd100;

    localparam logic [5:0] opRType = 6'b000000;
    localparam logic [5:0] opLoad = 6'b100011;
    localparam logic [5:0] opStore = 6'b101011;

    localparam logic [5:0] funcAdd = 6'b100000;
    localparam logic [5:0] funcSub = 6'b100010;
    localparam logic [5:0] funcAnd = 6'b100100;
    localparam logic [5:0] funcOr = 6'b100101;
    localparam logic [5:0] funcXor = 6'b100110;

    typedef enum logic [3:0] {
        aluAnd = 4'b0000,
        aluOr = 4'b0001,
        aluAdd = 4'b0010,
        aluSub = 4'b0110,
        aluXor = 4'b1111
    } aluOp;

    typedef enum logic [1:0] {
        fwdReg = 2'd0,
        fwdExe = 2'd1,
        fwdMem = 2'd2
    } fwdSel;

    // shared by the execute stage and the forward path in decode
    function automatic dataWord aluCompute(aluOp fn, dataWord a, dataWord b);
        case (fn)
            aluAnd: return a & b;
            aluOr: return a | b;
            aluAdd: return a + b;
            aluSub: return a - b;
            aluXor: return a ^ b;
            default: return '0;
        endcase
    endfunction

endpackage
